//--- rtl/axi_burst_macros.svh
`ifndef AXI_BURST_MACROS_SVH
`define AXI_BURST_MACROS_SVH

// bus geometry
`define AXI_ADDR_W      32
`define AXI_DATA_W      64
`define AXI_STRB_W      8
`define AXI_BEAT_SHIFT  3   // log2 of bytes per beat

// AXI4 burst length and response fields
`define AXI_LEN_W       8
`define AXI_RESP_W      2

// a burst must not cross this boundary
`define PAGE_BYTES      4096
`define PAGE_SHIFT      12

// user FIFO occupancy, up to 256 words
`define FIFO_CNT_W      9

`endif

//--- rtl/axi_burst_pkg.sv
`include "axi_burst_macros.svh"

package axi_burst_pkg;

    typedef logic [`AXI_ADDR_W-1:0]  addr_t;
    typedef logic [`AXI_DATA_W-1:0]  data_t;
    typedef logic [`AXI_STRB_W-1:0]  strb_t;
    typedef logic [`AXI_LEN_W-1:0]   len_t;      // beats minus one
    typedef logic [`AXI_RESP_W-1:0]  resp_t;     // 0 okay, 2 slverr, 3 decerr
    typedef logic [`FIFO_CNT_W-1:0]  fifo_cnt_t;

    // one INCR burst, also used for user commands
    typedef struct packed {
        addr_t addr;
        len_t  len;
    } burst_cmd_t;

    typedef struct packed {
        burst_cmd_t first;
        logic       split;  // second burst is needed
        burst_cmd_t second;
    } burst_plan_t;

    typedef struct packed {
        logic short_data;   // bit 1
        logic misaligned;   // bit 0
    } cmd_err_t;

    typedef enum logic [2:0] {wr_st_idle, wr_st_check, wr_st_address, wr_st_data, wr_st_response} wr_state_t;
    typedef enum logic [1:0] {rd_st_idle, rd_st_address, rd_st_data} rd_state_t;

endpackage

//--- rtl/burst_planner.sv
`include "axi_burst_macros.svh"

module burst_planner (
    input  axi_burst_pkg::burst_cmd_t  cmd,
    input  axi_burst_pkg::fifo_cnt_t   fifo_cnt,
    output axi_burst_pkg::burst_plan_t plan,
    output axi_burst_pkg::cmd_err_t    cmd_error
);

    logic [`PAGE_SHIFT:0]                 bytes_left;   // up to a full page
    logic [`PAGE_SHIFT-`AXI_BEAT_SHIFT:0] beats_left;
    logic [`AXI_LEN_W:0]                  beats_needed; // len plus one, 1..256
    logic                                 crosses;
    axi_burst_pkg::addr_t                 next_page;

    // room left in the current page
    always_comb
    begin
        bytes_left   = `PAGE_BYTES - {1'b0, cmd.addr[`PAGE_SHIFT-1:0]};
        beats_left   = bytes_left[`PAGE_SHIFT:`AXI_BEAT_SHIFT];
        beats_needed = {1'b0, cmd.len} + 1'b1;
        crosses      = {1'b0, beats_needed} > beats_left;
        next_page    = {cmd.addr[`AXI_ADDR_W-1:`PAGE_SHIFT] + 1'b1, {`PAGE_SHIFT{1'b0}}};
    end

    // a burst of at most 2 KiB crosses one boundary at most
    always_comb
    begin
        plan.first.addr  = cmd.addr;
        plan.split       = crosses;
        plan.second.addr = next_page;
        if (crosses)
        begin
            // beats_left is at most 255 here, so the low bits are enough
            plan.first.len  = beats_left[`AXI_LEN_W-1:0] - 1'b1;
            plan.second.len = cmd.len - beats_left[`AXI_LEN_W-1:0];
        end
        else
        begin
            plan.first.len  = cmd.len;
            plan.second.len = '0;
        end
    end

    always_comb
    begin
        cmd_error.misaligned = |cmd.addr[`AXI_BEAT_SHIFT-1:0];
        cmd_error.short_data = fifo_cnt < beats_needed; // whole command must be in the FIFO
    end

endmodule

//--- rtl/axi_write_engine.sv
module axi_write_engine (
    input  logic                       aclk,
    input  logic                       aresetn,
    input  logic                       start,
    input  axi_burst_pkg::burst_cmd_t  cmd,
    input  axi_burst_pkg::data_t       wdata_in,
    input  axi_burst_pkg::strb_t       wstrb_in,
    input  axi_burst_pkg::fifo_cnt_t   fifo_cnt,
    input  logic                       awready,
    input  logic                       wready,
    input  logic                       bvalid,
    input  axi_burst_pkg::resp_t       bresp,
    output logic                       free,
    output logic                       pop,
    output axi_burst_pkg::cmd_err_t    cmd_error,
    output axi_burst_pkg::resp_t       status,
    output axi_burst_pkg::burst_cmd_t  aw,
    output logic                       awvalid,
    output axi_burst_pkg::data_t       wdata,
    output axi_burst_pkg::strb_t       wstrb,
    output logic                       wvalid,
    output logic                       wlast,
    output logic                       bready
);

    axi_burst_pkg::wr_state_t   state;
    axi_burst_pkg::wr_state_t   state_nxt;
    axi_burst_pkg::burst_cmd_t  cmd_q;      // command as accepted
    axi_burst_pkg::burst_cmd_t  cur_cmd;    // burst on AW and W
    axi_burst_pkg::burst_cmd_t  second_q;   // tail of a split write
    axi_burst_pkg::burst_plan_t plan;
    axi_burst_pkg::cmd_err_t    plan_err;
    axi_burst_pkg::len_t        beat_cnt;
    logic                       cmd_pending;
    logic                       split_pending;
    logic                       free_q;
    logic                       accept;

    assign accept = start & free_q;

    burst_planner planner_inst (
        .cmd       (cmd_q),
        .fifo_cnt  (fifo_cnt),
        .plan      (plan),
        .cmd_error (plan_err)
    );

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
            state <= axi_burst_pkg::wr_st_idle;
        else
            state <= state_nxt;
    end

    always_comb
    begin
        state_nxt = state;
        case (state)
            axi_burst_pkg::wr_st_idle:
                if (cmd_pending) state_nxt = axi_burst_pkg::wr_st_check;
            axi_burst_pkg::wr_st_check:
                if (!split_pending && (plan_err != '0))
                    state_nxt = axi_burst_pkg::wr_st_idle;   // rejected, nothing on AXI
                else
                    state_nxt = axi_burst_pkg::wr_st_address;
            axi_burst_pkg::wr_st_address:
                if (awready) state_nxt = axi_burst_pkg::wr_st_data;
            axi_burst_pkg::wr_st_data:
                if (wready && wlast) state_nxt = axi_burst_pkg::wr_st_response;
            axi_burst_pkg::wr_st_response:
                if (bvalid)
                    state_nxt = split_pending ? axi_burst_pkg::wr_st_check
                                              : axi_burst_pkg::wr_st_idle;
            default:
                state_nxt = axi_burst_pkg::wr_st_idle;
        endcase
    end

    // free is registered, so a rejected command frees the engine one cycle after idle
    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            cmd_pending   <= 1'b0;
            split_pending <= 1'b0;
            free_q        <= 1'b1;
        end
        else
        begin
            free_q <= (state == axi_burst_pkg::wr_st_idle) & ~cmd_pending
                      & ~split_pending & ~accept;
            if (accept)
                cmd_pending <= 1'b1;
            else if (state == axi_burst_pkg::wr_st_idle)
                cmd_pending <= 1'b0;
            if (state == axi_burst_pkg::wr_st_check)
                split_pending <= split_pending ? 1'b0 : (plan.split & (plan_err == '0));
        end
    end

    always_ff @(posedge aclk)
    begin
        if (accept)
            cmd_q <= cmd;
        if (state == axi_burst_pkg::wr_st_check)
        begin
            if (split_pending)
                cur_cmd <= second_q;    // second half, no new check
            else
            begin
                cur_cmd  <= plan.first;
                second_q <= plan.second;
            end
        end
    end

    always_ff @(posedge aclk)
    begin
        if (!aresetn || state != axi_burst_pkg::wr_st_data)
            beat_cnt <= '0;
        else if (pop)
            beat_cnt <= beat_cnt + 1'b1;
    end

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            cmd_error <= '0;
            status    <= '0;
        end
        else if (accept)
        begin
            cmd_error <= '0;
            status    <= '0;
        end
        else
        begin
            if (state == axi_burst_pkg::wr_st_check && !split_pending)
                cmd_error <= plan_err;
            if (bvalid && bready)
                status <= bresp;
        end
    end

    assign free    = free_q;
    assign aw      = cur_cmd;
    assign awvalid = (state == axi_burst_pkg::wr_st_address);
    assign wvalid  = (state == axi_burst_pkg::wr_st_data); // data was counted up front
    assign wdata   = wdata_in;  // show-ahead FIFO head
    assign wstrb   = wstrb_in;
    assign wlast   = wvalid & (beat_cnt == cur_cmd.len);
    assign pop     = wvalid & wready;
    assign bready  = (state == axi_burst_pkg::wr_st_response);

endmodule

//--- rtl/axi_read_engine.sv
module axi_read_engine (
    input  logic                      aclk,
    input  logic                      aresetn,
    input  logic                      start,
    input  axi_burst_pkg::burst_cmd_t cmd,
    input  logic                      arready,
    input  logic                      rvalid,
    input  logic                      rlast,
    input  axi_burst_pkg::data_t      rdata,
    input  axi_burst_pkg::resp_t      rresp,
    input  logic                      fifo_full,
    output logic                      free,
    output axi_burst_pkg::burst_cmd_t ar,
    output logic                      arvalid,
    output logic                      rready,
    output logic                      push,
    output axi_burst_pkg::data_t      push_data,
    output axi_burst_pkg::resp_t      status
);

    axi_burst_pkg::rd_state_t  state;
    axi_burst_pkg::rd_state_t  state_nxt;
    axi_burst_pkg::burst_cmd_t cmd_q;
    logic                      accept;

    assign accept = start & free;

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
            state <= axi_burst_pkg::rd_st_idle;
        else
            state <= state_nxt;
    end

    always_comb
    begin
        state_nxt = state;
        case (state)
            axi_burst_pkg::rd_st_idle:
                if (accept) state_nxt = axi_burst_pkg::rd_st_address;
            axi_burst_pkg::rd_st_address:
                if (arready) state_nxt = axi_burst_pkg::rd_st_data;
            axi_burst_pkg::rd_st_data:
                if (push && rlast) state_nxt = axi_burst_pkg::rd_st_idle;
            default:
                state_nxt = axi_burst_pkg::rd_st_idle;
        endcase
    end

    always_ff @(posedge aclk)
    begin
        if (accept)
            cmd_q <= cmd;
    end

    // last beat's response wins
    always_ff @(posedge aclk)
    begin
        if (!aresetn || accept)
            status <= '0;
        else if (push)
            status <= rresp;
    end

    assign free      = (state == axi_burst_pkg::rd_st_idle);
    assign ar        = cmd_q;
    assign arvalid   = (state == axi_burst_pkg::rd_st_address);
    assign rready    = (state == axi_burst_pkg::rd_st_data) & ~fifo_full;
    assign push      = rvalid & rready;
    assign push_data = rdata;

endmodule

//--- rtl/axi_burst_master.sv
module axi_burst_master (
    input  logic                      aclk,
    input  logic                      aresetn,

    // user write side
    input  logic                      wr_start,
    input  axi_burst_pkg::burst_cmd_t wr_cmd,
    output logic                      wr_free,
    input  axi_burst_pkg::data_t      wr_data,
    input  axi_burst_pkg::strb_t      wr_strb,
    input  axi_burst_pkg::fifo_cnt_t  wr_fifo_cnt,
    output logic                      wr_pop,
    output axi_burst_pkg::cmd_err_t   wr_cmd_error,
    output axi_burst_pkg::resp_t      wr_status,

    // user read side
    input  logic                      rd_start,
    input  axi_burst_pkg::burst_cmd_t rd_cmd,
    output logic                      rd_free,
    output axi_burst_pkg::data_t      rd_data,
    output logic                      rd_push,
    input  logic                      rd_fifo_full,
    output axi_burst_pkg::resp_t      rd_status,

    // AXI4 master
    output axi_burst_pkg::burst_cmd_t m_axi_aw,
    output logic                      m_axi_awvalid,
    input  logic                      m_axi_awready,
    output axi_burst_pkg::data_t      m_axi_wdata,
    output axi_burst_pkg::strb_t      m_axi_wstrb,
    output logic                      m_axi_wlast,
    output logic                      m_axi_wvalid,
    input  logic                      m_axi_wready,
    input  axi_burst_pkg::resp_t      m_axi_bresp,
    input  logic                      m_axi_bvalid,
    output logic                      m_axi_bready,
    output axi_burst_pkg::burst_cmd_t m_axi_ar,
    output logic                      m_axi_arvalid,
    input  logic                      m_axi_arready,
    input  axi_burst_pkg::data_t      m_axi_rdata,
    input  axi_burst_pkg::resp_t      m_axi_rresp,
    input  logic                      m_axi_rlast,
    input  logic                      m_axi_rvalid,
    output logic                      m_axi_rready
);

    axi_write_engine write_engine_inst (
        .aclk (aclk), .aresetn (aresetn),
        .start (wr_start), .cmd (wr_cmd), .wdata_in (wr_data), .wstrb_in (wr_strb),
        .fifo_cnt (wr_fifo_cnt), .awready (m_axi_awready), .wready (m_axi_wready),
        .bvalid (m_axi_bvalid), .bresp (m_axi_bresp),
        .free (wr_free), .pop (wr_pop), .cmd_error (wr_cmd_error), .status (wr_status),
        .aw (m_axi_aw), .awvalid (m_axi_awvalid),
        .wdata (m_axi_wdata), .wstrb (m_axi_wstrb), .wvalid (m_axi_wvalid),
        .wlast (m_axi_wlast), .bready (m_axi_bready)
    );

    // runs independently of the write side
    axi_read_engine read_engine_inst (
        .aclk (aclk), .aresetn (aresetn),
        .start (rd_start), .cmd (rd_cmd), .arready (m_axi_arready),
        .rvalid (m_axi_rvalid), .rlast (m_axi_rlast), .rdata (m_axi_rdata),
        .rresp (m_axi_rresp), .fifo_full (rd_fifo_full),
        .free (rd_free), .ar (m_axi_ar), .arvalid (m_axi_arvalid),
        .rready (m_axi_rready), .push (rd_push), .push_data (rd_data), .status (rd_status)
    );

endmodule

//--- tb/axi_mem_model.sv
`include "axi_burst_macros.svh"

module axi_mem_model (
    input  logic                      aclk,
    input  logic                      aresetn,
    input  axi_burst_pkg::burst_cmd_t aw,
    input  logic                      awvalid,
    output logic                      awready = 1'b0,
    input  axi_burst_pkg::data_t      wdata,
    input  logic                      wlast,
    input  logic                      wvalid,
    output logic                      wready = 1'b0,
    output axi_burst_pkg::resp_t      bresp = '0,
    output logic                      bvalid = 1'b0,
    input  logic                      bready,
    input  axi_burst_pkg::burst_cmd_t ar,
    input  logic                      arvalid,
    output logic                      arready = 1'b0,
    output axi_burst_pkg::data_t      rdata = '0,
    output axi_burst_pkg::resp_t      rresp = '0,
    output logic                      rlast = 1'b0,
    output logic                      rvalid = 1'b0,
    input  logic                      rready,
    input  axi_burst_pkg::resp_t      wr_resp,
    input  axi_burst_pkg::resp_t      rd_resp
);

    timeunit 1ns;
    timeprecision 100ps;

    axi_burst_pkg::data_t      mem [axi_burst_pkg::addr_t];    // keyed by word address
    axi_burst_pkg::burst_cmd_t aw_log [$];
    axi_burst_pkg::burst_cmd_t ar_log [$];
    axi_burst_pkg::addr_t      wr_addr;
    axi_burst_pkg::addr_t      rd_addr;
    logic [`AXI_LEN_W:0]       rd_left;     // beats not yet presented on R
    logic                      b_pending;

    initial
    begin
        void'($urandom(32'h1ec9_1b6f));
    end

    always @(posedge aclk)
    begin
        if (!aresetn)
        begin
            awready   <= 1'b0;
            wready    <= 1'b0;
            arready   <= 1'b0;
            bvalid    <= 1'b0;
            bresp     <= '0;
            rvalid    <= 1'b0;
            rlast     <= 1'b0;
            rdata     <= '0;
            rresp     <= '0;
            wr_addr   <= '0;
            rd_addr   <= '0;
            rd_left   <= '0;
            b_pending <= 1'b0;
        end
        else
        begin
            // each ready stalls about one cycle in four
            awready <= ($urandom % 4) != 0;
            wready  <= ($urandom % 4) != 0;
            arready <= ($urandom % 4) != 0;

            if (awvalid && awready)
            begin
                aw_log.push_back(aw);
                wr_addr <= aw.addr;
            end
            if (wvalid && wready)
            begin
                mem[wr_addr >> `AXI_BEAT_SHIFT] = wdata;
                wr_addr <= wr_addr + `AXI_STRB_W;
                if (wlast)
                    b_pending <= 1'b1;
            end

            if (bvalid && bready)
            begin
                bvalid    <= 1'b0;
                b_pending <= 1'b0;
            end
            else if (b_pending && !bvalid && ($urandom % 2) == 0)
            begin
                bvalid <= 1'b1;
                bresp  <= wr_resp;  // set by the testbench per entry
            end

            if (arvalid && arready)
            begin
                ar_log.push_back(ar);
                rd_addr <= ar.addr;
                rd_left <= {1'b0, ar.len} + 1'b1;
            end
            else if ((!rvalid || rready) && rd_left != 0 && ($urandom % 4) != 0)
            begin
                rvalid  <= 1'b1;
                // unwritten words read back a fill made of their own address
                rdata   <= mem.exists(rd_addr >> `AXI_BEAT_SHIFT) ?
                           mem[rd_addr >> `AXI_BEAT_SHIFT] : {~rd_addr, rd_addr};
                rresp   <= rd_resp;
                rlast   <= (rd_left == 1);
                rd_addr <= rd_addr + `AXI_STRB_W;
                rd_left <= rd_left - 1'b1;
            end
            else if (rvalid && rready)
                rvalid <= 1'b0;
        end
    end

endmodule

//--- tb/tb_axi_burst_master.sv
`include "axi_burst_macros.svh"

module tb_axi_burst_master;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int                   wait_limit  = 4000;   // cycles per wait
    localparam axi_burst_pkg::resp_t resp_okay   = 2'd0;
    localparam axi_burst_pkg::resp_t resp_slverr = 2'd2;
    localparam axi_burst_pkg::resp_t resp_decerr = 2'd3;
    localparam axi_burst_pkg::data_t data_mask   = 64'h5a5a_c3c3_0ff0_a5a5;

    typedef struct packed {
        logic                      is_read;
        axi_burst_pkg::addr_t      addr;
        axi_burst_pkg::len_t       len;
        axi_burst_pkg::fifo_cnt_t  cnt;      // count claimed by the write FIFO
        axi_burst_pkg::resp_t      resp;     // injected on B or R
        axi_burst_pkg::cmd_err_t   err;
        logic [1:0]                n_bursts;
        axi_burst_pkg::burst_cmd_t first;
        axi_burst_pkg::burst_cmd_t second;
    } entry_t;

    logic                      aclk;
    logic                      aresetn;
    logic                      wr_start;
    axi_burst_pkg::burst_cmd_t wr_cmd;
    logic                      wr_free;
    axi_burst_pkg::data_t      wr_data = '0;
    axi_burst_pkg::strb_t      wr_strb = '1;
    axi_burst_pkg::fifo_cnt_t  wr_fifo_cnt;
    logic                      wr_pop;
    axi_burst_pkg::cmd_err_t   wr_cmd_error;
    axi_burst_pkg::resp_t      wr_status;
    logic                      rd_start;
    axi_burst_pkg::burst_cmd_t rd_cmd;
    logic                      rd_free;
    axi_burst_pkg::data_t      rd_data;
    logic                      rd_push;
    logic                      rd_fifo_full = 1'b0;
    axi_burst_pkg::resp_t      rd_status;
    axi_burst_pkg::burst_cmd_t m_axi_aw;
    logic                      m_axi_awvalid;
    logic                      m_axi_awready;
    axi_burst_pkg::data_t      m_axi_wdata;
    axi_burst_pkg::strb_t      m_axi_wstrb;
    logic                      m_axi_wlast;
    logic                      m_axi_wvalid;
    logic                      m_axi_wready;
    axi_burst_pkg::resp_t      m_axi_bresp;
    logic                      m_axi_bvalid;
    logic                      m_axi_bready;
    axi_burst_pkg::burst_cmd_t m_axi_ar;
    logic                      m_axi_arvalid;
    logic                      m_axi_arready;
    axi_burst_pkg::data_t      m_axi_rdata;
    axi_burst_pkg::resp_t      m_axi_rresp;
    logic                      m_axi_rlast;
    logic                      m_axi_rvalid;
    logic                      m_axi_rready;
    axi_burst_pkg::resp_t      wr_resp_inject;
    axi_burst_pkg::resp_t      rd_resp_inject;

    entry_t                    entries [$];
    axi_burst_pkg::data_t      rd_got [$];      // every word pushed into the read FIFO
    axi_burst_pkg::addr_t      fifo_base = '0;  // word address of the command's first beat
    int                        pop_total = 0;
    int                        pop_mark = 0;
    int                        error_count = 0;
    bit                        timed_out = 1'b0;
    string                     cur_tag = "reset";

    axi_burst_master axi_burst_master_inst (.*);

    axi_mem_model mem_model_inst (
        .aclk (aclk), .aresetn (aresetn),
        .aw (m_axi_aw), .awvalid (m_axi_awvalid), .awready (m_axi_awready),
        .wdata (m_axi_wdata), .wlast (m_axi_wlast), .wvalid (m_axi_wvalid),
        .wready (m_axi_wready),
        .bresp (m_axi_bresp), .bvalid (m_axi_bvalid), .bready (m_axi_bready),
        .ar (m_axi_ar), .arvalid (m_axi_arvalid), .arready (m_axi_arready),
        .rdata (m_axi_rdata), .rresp (m_axi_rresp), .rlast (m_axi_rlast),
        .rvalid (m_axi_rvalid), .rready (m_axi_rready),
        .wr_resp (wr_resp_inject), .rd_resp (rd_resp_inject)
    );

    initial
    begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    function automatic axi_burst_pkg::data_t pattern_word(input axi_burst_pkg::addr_t word);
        return {32'h0, word} ^ data_mask;
    endfunction

    function automatic axi_burst_pkg::strb_t strobe_pattern(input axi_burst_pkg::addr_t word);
        return word[7:0] ^ 8'hc3;
    endfunction

    // show-ahead write FIFO, head word follows the pops
    always @(posedge aclk)
    begin
        if (m_axi_wvalid && m_axi_wready)
            check_value({cur_tag, " wstrb"},
                        strobe_pattern(fifo_base + (pop_total - pop_mark)), m_axi_wstrb);
        if (wr_pop)
            pop_total <= pop_total + 1;
        wr_data <= pattern_word(fifo_base + (pop_total - pop_mark + int'(wr_pop)));
        wr_strb <= strobe_pattern(fifo_base + (pop_total - pop_mark + int'(wr_pop)));
    end

    always @(posedge aclk)
    begin
        rd_fifo_full <= ($urandom % 5) == 0;  // full about one cycle in five
        if (rd_push)
            rd_got.push_back(rd_data);
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual)
        begin
            $display("[ERROR] %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic end_run;
        $display("run complete with %0d errors", error_count);
        if (error_count == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    endtask

    task automatic wait_until_free(input logic is_read);
        int cycles;
        cycles = 0;
        do
        begin
            @(negedge aclk);
            cycles++;
        end
        while (!(is_read ? rd_free : wr_free) && cycles < wait_limit);
        if (!(is_read ? rd_free : wr_free))
        begin
            $display("timeout: the %s engine did not become free again",
                     is_read ? "read" : "write");
            error_count++;
            timed_out = 1'b1;
        end
    endtask

    task automatic add_entry(input logic is_read, input axi_burst_pkg::addr_t addr,
                             input axi_burst_pkg::len_t len,
                             input axi_burst_pkg::fifo_cnt_t cnt,
                             input axi_burst_pkg::resp_t resp,
                             input axi_burst_pkg::cmd_err_t err, input logic [1:0] n_bursts,
                             input axi_burst_pkg::burst_cmd_t first,
                             input axi_burst_pkg::burst_cmd_t second);
        entry_t e;
        e.is_read  = is_read;
        e.addr     = addr;
        e.len      = len;
        e.cnt      = cnt;
        e.resp     = resp;
        e.err      = err;
        e.n_bursts = n_bursts;
        e.first    = first;
        e.second   = second;
        entries.push_back(e);
    endtask

    task automatic build_table;
        // aligned write inside a page, read back
        add_entry(0, 32'h0000_0100, 8'd7, 9'd8, resp_okay, 2'b00, 1,
                  {32'h0000_0100, 8'd7}, '0);
        add_entry(1, 32'h0000_0100, 8'd7, 9'd0, resp_okay, 2'b00, 1,
                  {32'h0000_0100, 8'd7}, '0);
        // 6 beats across 0x1000 split into 2 + 4
        add_entry(0, 32'h0000_0ff0, 8'd5, 9'd6, resp_okay, 2'b00, 2,
                  {32'h0000_0ff0, 8'd1}, {32'h0000_1000, 8'd3});
        add_entry(1, 32'h0000_0ff0, 8'd1, 9'd0, resp_okay, 2'b00, 1,
                  {32'h0000_0ff0, 8'd1}, '0);
        add_entry(1, 32'h0000_1000, 8'd3, 9'd0, resp_okay, 2'b00, 1,
                  {32'h0000_1000, 8'd3}, '0);
        // rejected before any AXI traffic
        add_entry(0, 32'h0000_0204, 8'd3, 9'd4, resp_okay, 2'b01, 0, '0, '0);
        add_entry(0, 32'h0000_0300, 8'd7, 9'd7, resp_okay, 2'b10, 0, '0, '0);
        // error responses from the slave
        add_entry(0, 32'h0000_0400, 8'd3, 9'd4, resp_slverr, 2'b00, 1,
                  {32'h0000_0400, 8'd3}, '0);
        add_entry(1, 32'h0000_0400, 8'd3, 9'd0, resp_decerr, 2'b00, 1,
                  {32'h0000_0400, 8'd3}, '0);
        // ends exactly on a page boundary, no split
        add_entry(0, 32'h0000_3f80, 8'd15, 9'd20, resp_okay, 2'b00, 1,
                  {32'h0000_3f80, 8'd15}, '0);
        add_entry(1, 32'h0000_3f80, 8'd15, 9'd0, resp_okay, 2'b00, 1,
                  {32'h0000_3f80, 8'd15}, '0);
        // long burst split in half, read back as one burst
        add_entry(0, 32'h0000_7e00, 8'd127, 9'd256, resp_okay, 2'b00, 2,
                  {32'h0000_7e00, 8'd63}, {32'h0000_8000, 8'd63});
        add_entry(1, 32'h0000_7e00, 8'd127, 9'd0, resp_okay, 2'b00, 1,
                  {32'h0000_7e00, 8'd127}, '0);
    endtask

    task automatic run_entry(input int idx, input entry_t e);
        string                     tag;
        int                        aw_mark;
        int                        ar_mark;
        int                        push_mark;
        int                        n_seen;
        axi_burst_pkg::burst_cmd_t exp_burst;
        axi_burst_pkg::resp_t      exp_status;

        tag = $sformatf("entry %0d %s 0x%0h", idx, e.is_read ? "read" : "write", e.addr);
        exp_status = (e.err == '0) ? e.resp : resp_okay;   // rejected writes get no B
        wait_until_free(e.is_read);
        if (timed_out)
            return;
        cur_tag   = tag;
        aw_mark   = mem_model_inst.aw_log.size();
        ar_mark   = mem_model_inst.ar_log.size();
        push_mark = rd_got.size();
        @(posedge aclk);
        if (e.is_read)
        begin
            rd_start       <= 1'b1;
            rd_cmd         <= {e.addr, e.len};
            rd_resp_inject <= e.resp;
        end
        else
        begin
            wr_start       <= 1'b1;
            wr_cmd         <= {e.addr, e.len};
            wr_fifo_cnt    <= e.cnt;
            wr_resp_inject <= e.resp;
            fifo_base      <= e.addr >> `AXI_BEAT_SHIFT;
            pop_mark       <= pop_total;
        end
        @(posedge aclk);
        wr_start <= 1'b0;
        rd_start <= 1'b0;
        wait_until_free(e.is_read);
        if (timed_out)
            return;

        if (e.is_read)
        begin
            check_value({tag, " rd_status"}, exp_status, rd_status);
            n_seen = mem_model_inst.ar_log.size() - ar_mark;
            check_value({tag, " ar count"}, e.n_bursts, n_seen);
            if (n_seen > 0)
                check_value({tag, " ar"}, e.first, mem_model_inst.ar_log[ar_mark]);
            check_value({tag, " push count"}, e.len + 1, rd_got.size() - push_mark);
            for (int i = 0; i < rd_got.size() - push_mark; i++)
                check_value($sformatf("%s beat %0d", tag, i),
                            pattern_word((e.addr >> `AXI_BEAT_SHIFT) + i),
                            rd_got[push_mark + i]);
        end
        else
        begin
            check_value({tag, " wr_cmd_error"}, e.err, wr_cmd_error);
            check_value({tag, " wr_status"}, exp_status, wr_status);
            n_seen = mem_model_inst.aw_log.size() - aw_mark;
            check_value({tag, " aw count"}, e.n_bursts, n_seen);
            for (int i = 0; i < n_seen && i < 2; i++)
            begin
                exp_burst = (i == 0) ? e.first : e.second;
                check_value($sformatf("%s aw %0d", tag, i), exp_burst,
                            mem_model_inst.aw_log[aw_mark + i]);
            end
            check_value({tag, " pop count"}, (e.err == '0) ? e.len + 1 : 0,
                        pop_total - pop_mark);
        end
    endtask

    initial
    begin
        aresetn        = 1'b0;
        wr_start       = 1'b0;
        wr_cmd         = '0;
        wr_fifo_cnt    = '0;
        rd_start       = 1'b0;
        rd_cmd         = '0;
        wr_resp_inject = resp_okay;
        rd_resp_inject = resp_okay;
        build_table();
        repeat (16) @(posedge aclk);
        aresetn <= 1'b1;
        @(negedge aclk);
        // valids, readies and pulses low, both engines free
        check_value("reset outputs", 10'b00000000_11,
                    {m_axi_awvalid, m_axi_wvalid, m_axi_wlast, m_axi_bready,
                     m_axi_arvalid, m_axi_rready, wr_pop, rd_push, wr_free, rd_free});
        for (int i = 0; i < entries.size() && !timed_out; i++)
            run_entry(i, entries[i]);
        end_run();
    end

endmodule

//--- axi_burst_master.f
+incdir+rtl
rtl/axi_burst_pkg.sv
rtl/burst_planner.sv
rtl/axi_write_engine.sv
rtl/axi_read_engine.sv
rtl/axi_burst_master.sv
tb/axi_mem_model.sv
tb/tb_axi_burst_master.sv
